// File: common/uart_pkg.sv
package uart_pkg;

	localparam int ADDR_W = 3; // host register address width
	localparam int DL_W   = 16; // divisor latch width

	// register map, dlab steers 0 and 1 onto the divisor bytes
	localparam logic [ADDR_W-1:0] REG_RB_TR = 3'd0;
	localparam logic [ADDR_W-1:0] REG_IE    = 3'd1;
	localparam logic [ADDR_W-1:0] REG_II    = 3'd2; // read only
	localparam logic [ADDR_W-1:0] REG_LC    = 3'd3;
	localparam logic [ADDR_W-1:0] REG_MC    = 3'd4;
	localparam logic [ADDR_W-1:0] REG_LS    = 3'd5; // read only
	localparam logic [ADDR_W-1:0] REG_MS    = 3'd6; // read only
	localparam logic [ADDR_W-1:0] REG_SR    = 3'd7;

	typedef struct packed {
		logic       dlab;  // divisor latch access
		logic       brk;   // kept for readback
		logic       stick;
		logic       even;
		logic       pen;   // parity bits have no effect here
		logic       stop2; // second stop bit
		logic [1:0] wlen;  // data bits = 5 + wlen
	} lcr_t;

	typedef struct packed {
		logic ms;
		logic rls; // no receiver, stored only
		logic thre;
		logic rda; // stored only
	} ier_t;

	typedef struct packed {
		logic loop;
		logic out2;
		logic out1;
		logic rts;
		logic dtr; // bit 0
	} mcr_t;

	// pad levels, active low on the pins
	typedef struct packed {
		logic cts;
		logic dsr;
		logic ri;
		logic dcd;
	} modem_in_t;

	typedef struct packed {
		logic              we;
		logic              re;
		logic [ADDR_W-1:0] addr;
		logic [7:0]        dat;
	} bus_req_t;

	// one clock access strobes, dlab already resolved
	typedef struct packed {
		logic thr_write;
		logic iir_read;
		logic msr_read;
	} reg_strobe_t;

	localparam logic [2:0] II_THRE = 3'b001;
	localparam logic [2:0] II_MS   = 3'b000; // lowest priority

	localparam logic [7:0] LCR_RESET = 8'h03; // 8 data bits, 1 stop

endpackage

// File: regs/uart_reg_file.sv
module uart_reg_file (
	input  logic                       clk,
	input  logic                       wb_rst_i,
	input  uart_pkg::bus_req_t         bus_i,
	input  logic                       thre_i,
	input  logic                       temt_i,
	input  logic [7:0]                 msr_i,
	input  logic [3:0]                 iir_i,
	output logic [7:0]                 rd_dat_o,
	output uart_pkg::lcr_t             lcr_o,
	output uart_pkg::ier_t             ier_o,
	output uart_pkg::mcr_t             mcr_o,
	output logic [uart_pkg::DL_W-1:0]  dl_o,
	output logic                       dl_load_o,
	output logic                       thr_push_o,
	output logic [7:0]                 thr_dat_o,
	output uart_pkg::reg_strobe_t      strobe_o
);

	logic [7:0]                scratch;
	logic [uart_pkg::DL_W-1:0] dl;
	logic                      dlab;
	logic                      wr_rb;  // write to thr or dl1
	logic                      wr_ie;  // write to ier or dl2

	assign dlab  = lcr_o.dlab;
	assign wr_rb = bus_i.we && (bus_i.addr == uart_pkg::REG_RB_TR);
	assign wr_ie = bus_i.we && (bus_i.addr == uart_pkg::REG_IE);

	// access strobes
	assign strobe_o.thr_write = wr_rb && !dlab;
	assign strobe_o.iir_read  = bus_i.re && (bus_i.addr == uart_pkg::REG_II) && !dlab;
	assign strobe_o.msr_read  = bus_i.re && (bus_i.addr == uart_pkg::REG_MS) && !dlab;

	// byte goes straight to the holding register, loads on this edge
	assign thr_push_o = strobe_o.thr_write;
	assign thr_dat_o  = bus_i.dat;
	assign dl_o       = dl;

	// lcr
	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
			lcr_o <= uart_pkg::LCR_RESET;
		else if (bus_i.we && (bus_i.addr == uart_pkg::REG_LC))
			lcr_o <= bus_i.dat;
	end

	// ier shares its address with dl2
	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			ier_o           <= '0; // all sources off
			dl[uart_pkg::DL_W-1:8] <= '0;
		end
		else if (wr_ie)
		begin
			if (dlab)
				dl[uart_pkg::DL_W-1:8] <= bus_i.dat;
			else
				ier_o <= bus_i.dat[3:0]; // upper nibble unused
		end
	end

	// dl1 and the counter restart, one clock after the write
	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			dl[7:0]   <= '0;
			dl_load_o <= 1'b0;
		end
		else
		begin
			dl_load_o <= wr_rb && dlab; // dl already holds new byte then
			if (wr_rb && dlab)
				dl[7:0] <= bus_i.dat;
		end
	end

	// mcr and scratch
	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			mcr_o   <= '0;
			scratch <= '0;
		end
		else if (bus_i.we)
		begin
			if (bus_i.addr == uart_pkg::REG_MC)
				mcr_o <= bus_i.dat[4:0];
			if (bus_i.addr == uart_pkg::REG_SR)
				scratch <= bus_i.dat;
		end
	end

	// combinational read mux
	always_comb
	begin
		case (bus_i.addr)
			uart_pkg::REG_RB_TR: rd_dat_o = dlab ? dl[7:0] : 8'h00; // no receiver
			uart_pkg::REG_IE:    rd_dat_o = dlab ? dl[uart_pkg::DL_W-1:8] : {4'b0000, ier_o};
			uart_pkg::REG_II:    rd_dat_o = {4'b1100, iir_i};
			uart_pkg::REG_LC:    rd_dat_o = lcr_o;
			uart_pkg::REG_MC:    rd_dat_o = {3'b000, mcr_o};
			uart_pkg::REG_LS:    rd_dat_o = {1'b0, temt_i, thre_i, 5'b00000}; // only tx status
			uart_pkg::REG_MS:    rd_dat_o = msr_i;
			uart_pkg::REG_SR:    rd_dat_o = scratch;
			default:             rd_dat_o = 8'h00;
		endcase
	end

endmodule

// File: rtl/uart_baud_gen.sv
module uart_baud_gen (
	input  logic                      clk,
	input  logic                      wb_rst_i,
	input  logic [uart_pkg::DL_W-1:0] dl_i,      // divisor
	input  logic                      dl_load_i, // dl1 written
	output logic                      baud_en_o
);

	logic [uart_pkg::DL_W-1:0] dlc; // down counter
	logic                      dlc_zero;

	assign dlc_zero = (dlc == '0);

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
			dlc <= '0;
		else if (dl_load_i || dlc_zero)
			dlc <= dl_i - 1'b1; // preset, wraps harmlessly when dl is 0
		else
			dlc <= dlc - 1'b1;
	end

	// one pulse every dl clocks
	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
			baud_en_o <= 1'b0;
		else
			baud_en_o <= dlc_zero && (dl_i != '0); // dl of 0 stops the line
	end

endmodule

// File: rtl/uart_int_ctrl.sv
module uart_int_ctrl (
	input  logic                  clk,
	input  logic                  wb_rst_i,
	input  uart_pkg::ier_t        ier_i,
	input  logic                  thre_i,
	input  logic [3:0]            msr_delta_i,
	input  uart_pkg::reg_strobe_t strobe_i,
	output logic [3:0]            iir_o,     // {id, no pending}
	output logic                  int_o
);

	logic thre_src;
	logic ms_src;
	logic thre_src_d;   // rise detect delay
	logic ms_src_d;
	logic thre_pnd;
	logic ms_pnd;
	logic thre_pnd_nxt;
	logic ms_pnd_nxt;
	logic iir_is_thre;  // iir currently shows thre

	assign thre_src    = ier_i.thre && thre_i;
	assign ms_src      = ier_i.ms && (|msr_delta_i);
	assign iir_is_thre = (iir_o == {uart_pkg::II_THRE, 1'b0});

	// clear, then set on rise, else drop when masked
	always_comb
	begin
		if (strobe_i.thr_write || (strobe_i.iir_read && iir_is_thre))
			thre_pnd_nxt = 1'b0;
		else if (thre_src && !thre_src_d)
			thre_pnd_nxt = 1'b1;
		else
			thre_pnd_nxt = thre_pnd && ier_i.thre;

		if (strobe_i.msr_read)
			ms_pnd_nxt = 1'b0;
		else if (ms_src && !ms_src_d)
			ms_pnd_nxt = 1'b1;
		else
			ms_pnd_nxt = ms_pnd && ier_i.ms;
	end

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			thre_src_d <= 1'b0;
			ms_src_d   <= 1'b0;
			thre_pnd   <= 1'b0;
			ms_pnd     <= 1'b0;
			int_o      <= 1'b0;
		end
		else
		begin
			thre_src_d <= thre_src;
			ms_src_d   <= ms_src;
			thre_pnd   <= thre_pnd_nxt;
			ms_pnd     <= ms_pnd_nxt;
			int_o      <= thre_pnd_nxt || ms_pnd_nxt; // drops right after the clearing access
		end
	end

	// iir follows the flags one clock later, thre wins
	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
			iir_o <= 4'b0001;
		else if (thre_pnd)
			iir_o <= {uart_pkg::II_THRE, 1'b0};
		else if (ms_pnd)
			iir_o <= {uart_pkg::II_MS, 1'b0};
		else
			iir_o <= 4'b0001; // nothing pending
	end

endmodule

// File: rtl/uart_lite_top.sv
module uart_lite_top #(
	parameter int OVERSAMPLE = 16 // baud enables per serial bit
) (
	input  logic                         clk,
	input  logic                         wb_rst_i,
	input  logic [uart_pkg::ADDR_W-1:0]  wb_addr_i,
	input  logic [7:0]                   wb_dat_i,
	output logic [7:0]                   wb_dat_o,
	input  logic                         wb_we_i,
	input  logic                         wb_re_i,
	input  uart_pkg::modem_in_t          modem_i, // raw pads, active low
	output logic                         stx_pad_o,
	output logic                         rts_pad_o,
	output logic                         dtr_pad_o,
	output logic                         int_o
);

	uart_pkg::bus_req_t    bus;
	uart_pkg::lcr_t        lcr;
	uart_pkg::ier_t        ier;
	uart_pkg::mcr_t        mcr;
	uart_pkg::reg_strobe_t strobe;
	logic [uart_pkg::DL_W-1:0] dl;
	logic                  dl_load;   // restart baud count
	logic                  thr_push;
	logic [7:0]            thr_dat;
	logic                  baud_en;
	logic                  serial_out; // tx line before loopback
	logic                  thre;
	logic                  temt;
	logic [7:0]            msr;
	logic [3:0]            iir;

	// one bus cycle as a struct
	assign bus = '{we: wb_we_i, re: wb_re_i, addr: wb_addr_i, dat: wb_dat_i};

	uart_reg_file u_reg_file (
		.clk        (clk),
		.wb_rst_i   (wb_rst_i),
		.bus_i      (bus),
		.thre_i     (thre),
		.temt_i     (temt),
		.msr_i      (msr),
		.iir_i      (iir),
		.rd_dat_o   (wb_dat_o),
		.lcr_o      (lcr),
		.ier_o      (ier),
		.mcr_o      (mcr),
		.dl_o       (dl),
		.dl_load_o  (dl_load),
		.thr_push_o (thr_push),
		.thr_dat_o  (thr_dat),
		.strobe_o   (strobe)
	);

	uart_baud_gen u_baud_gen (
		.clk       (clk),
		.wb_rst_i  (wb_rst_i),
		.dl_i      (dl),
		.dl_load_i (dl_load),
		.baud_en_o (baud_en)
	);

	uart_tx_serializer #(.OVERSAMPLE(OVERSAMPLE)) u_tx (
		.clk       (clk),
		.wb_rst_i  (wb_rst_i),
		.baud_en_i (baud_en),
		.lcr_i     (lcr),
		.push_i    (thr_push),
		.dat_i     (thr_dat),
		.serial_o  (serial_out),
		.thre_o    (thre),
		.temt_o    (temt)
	);

	uart_modem_ctrl u_modem (
		.clk       (clk),
		.wb_rst_i  (wb_rst_i),
		.modem_i   (modem_i),
		.mcr_i     (mcr),
		.serial_i  (serial_out),
		.strobe_i  (strobe),
		.msr_o     (msr),
		.stx_pad_o (stx_pad_o),
		.rts_pad_o (rts_pad_o),
		.dtr_pad_o (dtr_pad_o)
	);

	uart_int_ctrl u_int (
		.clk         (clk),
		.wb_rst_i    (wb_rst_i),
		.ier_i       (ier),
		.thre_i      (thre),
		.msr_delta_i (msr[3:0]), // ddcd, teri, ddsr, dcts
		.strobe_i    (strobe),
		.iir_o       (iir),
		.int_o       (int_o)
	);

endmodule

// File: rtl/uart_modem_ctrl.sv
module uart_modem_ctrl (
	input  logic                  clk,
	input  logic                  wb_rst_i,
	input  uart_pkg::modem_in_t   modem_i,
	input  uart_pkg::mcr_t        mcr_i,
	input  logic                  serial_i,  // from the transmitter
	input  uart_pkg::reg_strobe_t strobe_i,
	output logic [7:0]            msr_o,
	output logic                  stx_pad_o,
	output logic                  rts_pad_o,
	output logic                  dtr_pad_o
);

	logic [3:0] modem_act;  // inverted pads, {dcd, ri, dsr, cts}
	logic [3:0] modem_d;    // previous modem_act
	logic [3:0] status_lvl; // msr 7..4 source
	logic       msi_clr;    // clears the delta bits

	assign modem_act = ~{modem_i.dcd, modem_i.ri, modem_i.dsr, modem_i.cts};

	// loopback feeds mcr outputs back in place of the pads
	assign status_lvl = mcr_i.loop ? {mcr_i.out2, mcr_i.out1, mcr_i.dtr, mcr_i.rts}
	                               : {modem_i.dcd, modem_i.ri, modem_i.dsr, modem_i.cts};

	assign stx_pad_o = mcr_i.loop ? 1'b1 : serial_i; // line held idle in loopback
	assign rts_pad_o = mcr_i.rts;
	assign dtr_pad_o = mcr_i.dtr;

	// one clock clear after reset or an msr read
	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
			msi_clr <= 1'b1;
		else if (msi_clr)
			msi_clr <= 1'b0;
		else if (strobe_i.msr_read)
			msi_clr <= 1'b1;
	end

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			msr_o   <= '0;
			modem_d <= '0;
		end
		else
		begin
			// delta bits are sticky until cleared
			msr_o[3:0] <= msi_clr ? 4'b0000 : msr_o[3:0] | (modem_act ^ modem_d);
			msr_o[7:4] <= status_lvl;
			modem_d    <= modem_act;
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# build and run the uart_lite testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f uart_lite.f --top-module tb_uart_lite -o tb_uart_lite
./obj_dir/tb_uart_lite

// File: tx/uart_tx_serializer.sv
module uart_tx_serializer #(
	parameter int OVERSAMPLE = 16
) (
	input  logic           clk,
	input  logic           wb_rst_i,
	input  logic           baud_en_i,
	input  uart_pkg::lcr_t lcr_i,
	input  logic           push_i,
	input  logic [7:0]     dat_i,
	output logic           serial_o,
	output logic           thre_o,
	output logic           temt_o
);

	localparam int TICK_W = (OVERSAMPLE > 1) ? $clog2(OVERSAMPLE) : 1;
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(OVERSAMPLE - 1);

	localparam logic [1:0] S_IDLE  = 2'd0;
	localparam logic [1:0] S_START = 2'd1;
	localparam logic [1:0] S_DATA  = 2'd2;
	localparam logic [1:0] S_STOP  = 2'd3;

	logic [1:0]        state;
	logic [TICK_W-1:0] tick;     // enables within one bit
	logic [2:0]        bit_cnt;  // data or stop bit index
	logic [7:0]        thr;      // holding register
	logic              thr_full;
	logic [7:0]        shifter;
	logic              push_ok;
	logic              ld_shift; // thr into shifter
	logic              bit_end;  // last enable of a bit
	logic              shift_step;
	logic [2:0]        last_data;
	logic              last_stop;

	assign push_ok    = push_i && !thr_full; // full thr drops the write
	assign ld_shift   = (state == S_IDLE) && baud_en_i && thr_full;
	assign bit_end    = baud_en_i && (tick == TICK_LAST);
	assign shift_step = bit_end && ((state == S_START) || (state == S_DATA));
	assign last_data  = 3'd4 + {1'b0, lcr_i.wlen};
	assign last_stop  = (bit_cnt == {2'b00, lcr_i.stop2});

	assign thre_o = !thr_full;
	assign temt_o = !thr_full && (state == S_IDLE);

	// payload, no reset
	always_ff @(posedge clk)
	begin
		if (push_ok)
			thr <= dat_i;
		if (ld_shift)
			shifter <= thr;
		else if (shift_step)
			shifter <= shifter >> 1; // lsb first
	end

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			state    <= S_IDLE;
			tick     <= '0;
			bit_cnt  <= '0;
			thr_full <= 1'b0;
			serial_o <= 1'b1; // line idles high
		end
		else
		begin
			if (push_ok)
				thr_full <= 1'b1;
			else if (ld_shift)
				thr_full <= 1'b0; // thre back on

			if (state != S_IDLE && baud_en_i)
				tick <= bit_end ? '0 : tick + 1'b1;

			case (state)
				S_IDLE:
					if (ld_shift)
					begin
						state    <= S_START;
						tick     <= '0;
						serial_o <= 1'b0; // start bit
					end
				S_START:
					if (bit_end)
					begin
						state    <= S_DATA;
						bit_cnt  <= '0;
						serial_o <= shifter[0];
					end
				S_DATA:
					if (bit_end)
					begin
						if (bit_cnt == last_data)
						begin
							state    <= S_STOP;
							bit_cnt  <= '0;
							serial_o <= 1'b1;
						end
						else
						begin
							bit_cnt  <= bit_cnt + 1'b1;
							serial_o <= shifter[0];
						end
					end
				default: // stop bits
					if (bit_end)
					begin
						if (last_stop)
							state <= S_IDLE;
						else
							bit_cnt <= bit_cnt + 1'b1;
					end
			endcase
		end
	end

endmodule

// File: uart_lite.f
+incdir+verif
common/uart_pkg.sv
regs/uart_reg_file.sv
rtl/uart_baud_gen.sv
tx/uart_tx_serializer.sv
rtl/uart_modem_ctrl.sv
rtl/uart_int_ctrl.sv
rtl/uart_lite_top.sv
verif/tb_uart_lite.sv

// File: verif/tb_uart_tests.svh
// msr 7..4 levels from the pads, dcd ri dsr cts
function automatic logic [3:0] msr_levels();
	return {modem_pads.dcd, modem_pads.ri, modem_pads.dsr, modem_pads.cts};
endfunction

// dl2 first so the dl1 restart loads the whole divisor
task automatic set_divisor(input logic [15:0] dl);
	bus_write(uart_pkg::REG_LC, 8'h83);
	bus_write(uart_pkg::REG_IE, dl[15:8]);
	bus_write(uart_pkg::REG_RB_TR, dl[7:0]);
	bus_write(uart_pkg::REG_LC, 8'h03);
endtask

task automatic reset_values();
	read_check(uart_pkg::REG_LC, 8'h03, "LCR after reset");
	read_check(uart_pkg::REG_IE, 8'h00, "IER after reset");
	read_check(uart_pkg::REG_II, 8'hc1, "IIR after reset");
	read_check(uart_pkg::REG_LS, 8'h60, "LSR after reset");
	read_check(uart_pkg::REG_MC, 8'h00, "MCR after reset");
	read_check(uart_pkg::REG_SR, 8'h00, "scratch after reset");
	// stx rts dtr int
	expect_eq("pads after reset", 8'h08, {4'h0, stx_pad_o, rts_pad_o, dtr_pad_o, int_o});
endtask

task automatic register_access();
	logic [7:0] sr_val;
	logic [7:0] lcr_val;
	logic [7:0] mcr_val;
	logic [7:0] ier_val;
	logic [7:0] dl1;
	logic [7:0] dl2;
	sr_val  = 8'($urandom());
	lcr_val = 8'($urandom());
	mcr_val = 8'($urandom());
	ier_val = 8'($urandom());
	dl1     = 8'($urandom());
	dl2     = 8'($urandom());
	bus_write(uart_pkg::REG_SR, sr_val);
	read_check(uart_pkg::REG_SR, sr_val, "scratch");
	bus_write(uart_pkg::REG_LC, lcr_val);
	read_check(uart_pkg::REG_LC, lcr_val, "LCR");
	bus_write(uart_pkg::REG_LC, 8'h03);
	bus_write(uart_pkg::REG_MC, mcr_val);
	read_check(uart_pkg::REG_MC, mcr_val & 8'h1f, "MCR"); // only 5 bits exist
	bus_write(uart_pkg::REG_MC, 8'h00);
	bus_write(uart_pkg::REG_IE, ier_val); // ier set before the divisor bytes
	bus_write(uart_pkg::REG_LC, 8'h83);
	bus_write(uart_pkg::REG_RB_TR, dl1);
	bus_write(uart_pkg::REG_IE, dl2);
	read_check(uart_pkg::REG_RB_TR, dl1, "DL1");
	read_check(uart_pkg::REG_IE, dl2, "DL2");
	bus_write(uart_pkg::REG_LC, 8'h03);
	read_check(uart_pkg::REG_IE, ier_val & 8'h0f, "IER after DL writes");
	bus_write(uart_pkg::REG_IE, 8'h00);
endtask

// one frame, bit time 16 x divisor 2 = 32 clocks
task automatic send_frame(input logic [7:0] dat, input logic [1:0] wlen, input logic stop2);
	int nbits;
	int i;
	nbits = 5 + int'(wlen);
	bus_write(uart_pkg::REG_LC, {5'b00000, stop2, wlen});
	bus_write(uart_pkg::REG_RB_TR, dat);
	read_check(uart_pkg::REG_LS, 8'h00, "LSR after push");
	wait_level(SIG_STX, 1'b0, 64, "the start bit");
	repeat (16) @(negedge clk); // middle of start bit
	expect_eq("start bit", 8'h00, {7'b0, stx_pad_o});
	for (i = 0; i < nbits; i++)
	begin
		repeat (32) @(negedge clk);
		expect_eq($sformatf("data bit %0d", i), {7'b0, dat[i]}, {7'b0, stx_pad_o});
	end
	for (i = 0; i < 1 + int'(stop2); i++)
	begin
		repeat (32) @(negedge clk);
		expect_eq($sformatf("stop bit %0d", i), 8'h01, {7'b0, stx_pad_o});
	end
	read_check(uart_pkg::REG_LS, 8'h20, "LSR during the last stop bit"); // thr empty, shifter busy
	wait_tx_idle(64);
endtask

task automatic transmit_frames();
	set_divisor(16'd2);
	send_frame(8'($urandom()), 2'd3, 1'b0); // 8 data, 1 stop
	send_frame(8'($urandom()), 2'd0, 1'b1); // 5 data, 2 stop
	bus_write(uart_pkg::REG_LC, 8'h03);
endtask

task automatic thre_interrupt();
	// cleared by reading iir
	bus_write(uart_pkg::REG_IE, 8'h02);
	wait_level(SIG_INT, 1'b1, 8, "the THRE interrupt");
	@(negedge clk); // iir lags the pending flag by a clock
	read_check(uart_pkg::REG_II, 8'hc2, "IIR with THRE pending");
	wait_level(SIG_INT, 1'b0, 2, "int_o to fall after the IIR read");
	@(negedge clk);
	read_check(uart_pkg::REG_II, 8'hc1, "IIR after the IIR read");
	// cleared by a thr write, divisor 0 keeps the byte in the holding register
	bus_write(uart_pkg::REG_IE, 8'h00);
	set_divisor(16'd0);
	bus_write(uart_pkg::REG_IE, 8'h02);
	wait_level(SIG_INT, 1'b1, 8, "the THRE interrupt");
	bus_write(uart_pkg::REG_RB_TR, 8'($urandom()));
	wait_level(SIG_INT, 1'b0, 2, "int_o to fall after the THR write");
	@(negedge clk);
	read_check(uart_pkg::REG_II, 8'hc1, "IIR after the THR write");
	read_check(uart_pkg::REG_LS, 8'h00, "LSR with byte held");
	bus_write(uart_pkg::REG_IE, 8'h00);
	set_divisor(16'd2); // let the held byte drain
	wait_tx_idle(800);
endtask

task automatic modem_status_loopback();
	logic [1:0] sel;
	logic [3:0] delta;
	logic [3:0] pattern;
	read_check(uart_pkg::REG_MS, {msr_levels(), 4'h0}, "MSR before pad change");
	bus_write(uart_pkg::REG_IE, 8'h08);
	sel   = 2'($urandom());
	delta = 4'b0001 << sel; // dcts ddsr teri ddcd
	modem_pads[~sel] = ~modem_pads[~sel]; // pad bits run cts dsr ri dcd from the top
	wait_level(SIG_INT, 1'b1, 8, "the modem status interrupt");
	@(negedge clk);
	read_check(uart_pkg::REG_II, 8'hc0, "IIR with modem status pending");
	read_check(uart_pkg::REG_MS, {msr_levels(), delta}, "MSR after pad change");
	wait_level(SIG_INT, 1'b0, 2, "int_o to fall after the MSR read");
	@(negedge clk); // deltas clear a clock after the read
	read_check(uart_pkg::REG_MS, {msr_levels(), 4'h0}, "MSR after the MSR read");
	read_check(uart_pkg::REG_II, 8'hc1, "IIR after the MSR read");
	bus_write(uart_pkg::REG_IE, 8'h00);
	// loopback, pattern is out2 out1 rts dtr
	pattern = 4'($urandom());
	bus_write(uart_pkg::REG_MC, {4'b0001, pattern});
	@(negedge clk);
	read_check(uart_pkg::REG_MS, {pattern[3], pattern[2], pattern[0], pattern[1], 4'h0},
		"MSR in loopback");
	bus_write(uart_pkg::REG_RB_TR, 8'h00); // frame runs behind the held pad
	repeat (16) @(negedge clk); // inside the start bit
	expect_eq("stx_pad_o in loopback", 8'h01, {7'b0, stx_pad_o});
	read_check(uart_pkg::REG_LS, 8'h20, "LSR with loopback frame running");
	wait_tx_idle(400);
	pattern = 4'($urandom());
	bus_write(uart_pkg::REG_MC, {4'b0000, pattern});
	expect_eq("rts and dtr pads", {6'b0, pattern[1], pattern[0]},
		{6'b0, rts_pad_o, dtr_pad_o});
	bus_write(uart_pkg::REG_MC, 8'h00);
endtask

// File: verif/tb_uart_lite.sv
module tb_uart_lite;

	localparam int SIG_STX = 0; // wait_level selectors
	localparam int SIG_INT = 1;

	logic                        clk;
	logic                        wb_rst_i;
	logic [uart_pkg::ADDR_W-1:0] wb_addr_i;
	logic [7:0]                  wb_dat_i;
	logic [7:0]                  wb_dat_o;
	logic                        wb_we_i;
	logic                        wb_re_i;
	uart_pkg::modem_in_t         modem_pads; // active low
	logic                        stx_pad_o;
	logic                        rts_pad_o;
	logic                        dtr_pad_o;
	logic                        int_o;

	uart_lite_top dut0 (
		.clk       (clk),
		.wb_rst_i  (wb_rst_i),
		.wb_addr_i (wb_addr_i),
		.wb_dat_i  (wb_dat_i),
		.wb_dat_o  (wb_dat_o),
		.wb_we_i   (wb_we_i),
		.wb_re_i   (wb_re_i),
		.modem_i   (modem_pads),
		.stx_pad_o (stx_pad_o),
		.rts_pad_o (rts_pad_o),
		.dtr_pad_o (dtr_pad_o),
		.int_o     (int_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic expect_eq(input string what, input logic [7:0] expected,
		input logic [7:0] actual);
		assert (actual === expected)
		else
			fail_stop($sformatf("error at time %0t: %s expected %02h got %02h",
				$time, what, expected, actual));
	endtask

	// starts on a falling edge, ends on the next one
	task automatic bus_write(input logic [uart_pkg::ADDR_W-1:0] addr, input logic [7:0] dat);
		wb_addr_i = addr;
		wb_dat_i  = dat;
		wb_we_i   = 1'b1;
		@(negedge clk); // register loads on the edge in between
		wb_we_i = 1'b0;
	endtask

	task automatic bus_read(input logic [uart_pkg::ADDR_W-1:0] addr, output logic [7:0] dat);
		wb_addr_i = addr;
		wb_re_i   = 1'b1;
		#10;
		dat = wb_dat_o; // combinational read, settled well before the edge
		@(negedge clk);
		wb_re_i = 1'b0;
	endtask

	task automatic read_check(input logic [uart_pkg::ADDR_W-1:0] addr,
		input logic [7:0] expected, input string what);
		logic [7:0] got;
		bus_read(addr, got);
		expect_eq(what, expected, got);
	endtask

	function automatic logic pad_level(input int sel);
		return (sel == SIG_STX) ? stx_pad_o : int_o;
	endfunction

	// polls on falling edges
	task automatic wait_level(input int sel, input logic level, input int limit,
		input string what);
		int n;
		n = 0;
		while (pad_level(sel) !== level)
		begin
			if (n == limit)
				fail_stop($sformatf("timeout while waiting for %s", what));
			@(negedge clk);
			n++;
		end
	endtask

	// polls lsr until thre and temt are both back
	task automatic wait_tx_idle(input int limit);
		logic [7:0] lsr;
		int n;
		n = 0;
		bus_read(uart_pkg::REG_LS, lsr);
		while (lsr !== 8'h60)
		begin
			if (n == limit)
				fail_stop("timeout while waiting for the transmitter to become empty");
			bus_read(uart_pkg::REG_LS, lsr);
			n++;
		end
	endtask

	`include "tb_uart_tests.svh"

	initial
	begin
		void'($urandom(32'h3c89_3950));
		wb_rst_i   = 1'b1;
		wb_addr_i  = '0;
		wb_dat_i   = '0;
		wb_we_i    = 1'b0;
		wb_re_i    = 1'b0;
		modem_pads = '1; // all modem lines inactive
		repeat (3) @(posedge clk);
		@(negedge clk);
		wb_rst_i = 1'b0;
		reset_values();
		register_access();
		transmit_frames();
		thre_interrupt();
		modem_status_loopback();
		$display("Test passed");
		$finish;
	end

endmodule
